// File: common/uart_pkg.sv
package uart_pkg;

    // Frame format, fixed at 8N1
    localparam int DATA_BITS  = 8;
    localparam int OVERSAMPLE = 16;
    localparam int DIV_W      = 16;

    typedef logic [DATA_BITS-1:0] uart_byte_t;

    // Received byte with the stop bit check result on top
    typedef struct packed {
        logic       frame_err;
        uart_byte_t data;
    } rx_word_t;

    // Register map
    localparam logic [31:0] ADDR_DATA   = 32'h0;
    localparam logic [31:0] ADDR_STATUS = 32'h4;
    localparam logic [31:0] ADDR_DIV    = 32'h8;

    // STATUS bits
    localparam int STAT_TX_FULL    = 0;
    localparam int STAT_TX_EMPTY   = 1;
    localparam int STAT_RX_EMPTY   = 2;
    localparam int STAT_RX_OVERRUN = 3;
    localparam int STAT_FRAME_ERR  = 4;

endpackage

// File: logic/sync_fifo.sv
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_push,
    input  payload_t i_data,
    input  logic     i_pop,
    output payload_t o_data,
    output logic     o_full,
    output logic     o_empty
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head of queue is always visible
    assign o_data  = mem[rd_ptr];
    assign o_full  = count == (PTR_W + 1)'(DEPTH);
    assign o_empty = count == '0;

endmodule

// File: logic/baud_tick.sv
module baud_tick
    import uart_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic [DIV_W-1:0] i_div,
    output logic             o_tick
);

    logic [DIV_W-1:0] count;

    // Counts div down to zero, so one tick per div+1 cycles
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            count <= '0;
        end else if (count == '0) begin
            count <= i_div;
        end else begin
            count <= count - 1'b1;
        end
    end

    assign o_tick = count == '0;

endmodule

// File: uart/uart_regs.sv
module uart_regs
    import uart_pkg::*;
#(
    parameter int CLK_FREQ  = 1600000,
    parameter int BAUD_RATE = 100000
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_psel,
    input  logic             i_penable,
    input  logic             i_pwrite,
    input  logic [3:0]       i_paddr,
    input  logic [31:0]      i_pwdata,
    output logic [31:0]      o_prdata,
    output logic [DIV_W-1:0] o_div,
    output logic             o_tx_push,
    output uart_byte_t       o_tx_data,
    input  logic             i_tx_full,
    input  logic             i_tx_empty,
    output logic             o_rx_pop,
    input  rx_word_t         i_rx_data,
    input  logic             i_rx_empty,
    input  logic             i_rx_push,
    input  logic             i_rx_full
);

    localparam int DIV_RESET = CLK_FREQ / (BAUD_RATE * OVERSAMPLE) - 1;

    logic access;
    logic wr_en;
    logic rd_en;
    logic sel_data;
    logic sel_status;
    logic sel_div;
    logic overrun;
    logic frame_err;
    logic head_load;

    // Zero-wait APB, everything happens in the access phase
    assign access     = i_psel && i_penable;
    assign wr_en      = access && i_pwrite;
    assign rd_en      = access && !i_pwrite;
    assign sel_data   = i_paddr == ADDR_DATA[3:0];
    assign sel_status = i_paddr == ADDR_STATUS[3:0];
    assign sel_div    = i_paddr == ADDR_DIV[3:0];

    // Writes to a full TX FIFO are dropped
    assign o_tx_push = wr_en && sel_data && !i_tx_full;
    assign o_tx_data = i_pwdata[DATA_BITS-1:0];
    assign o_rx_pop  = rd_en && sel_data && !i_rx_empty;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_div <= DIV_W'(DIV_RESET);
        end else if (wr_en && sel_div) begin
            o_div <= i_pwdata[DIV_W-1:0];
        end
    end

    // A new word shows at the FIFO head after a pop or a push into an empty FIFO
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            head_load <= 1'b0;
        end else begin
            head_load <= o_rx_pop || (i_rx_push && i_rx_empty);
        end
    end

    // Sticky flags, a set in the same cycle wins over the clear
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            if (wr_en && sel_status && i_pwdata[STAT_RX_OVERRUN]) begin
                overrun <= 1'b0;
            end
            if (wr_en && sel_status && i_pwdata[STAT_FRAME_ERR]) begin
                frame_err <= 1'b0;
            end
            if (i_rx_push && i_rx_full) begin
                overrun <= 1'b1;
            end
            if (head_load && !i_rx_empty && i_rx_data.frame_err) begin
                frame_err <= 1'b1;
            end
        end
    end

    always_comb begin
        o_prdata = '0;
        if (sel_data) begin
            if (!i_rx_empty) begin
                o_prdata[$bits(rx_word_t)-1:0] = i_rx_data;
            end
        end else if (sel_status) begin
            o_prdata[STAT_TX_FULL]    = i_tx_full;
            o_prdata[STAT_TX_EMPTY]   = i_tx_empty;
            o_prdata[STAT_RX_EMPTY]   = i_rx_empty;
            o_prdata[STAT_RX_OVERRUN] = overrun;
            o_prdata[STAT_FRAME_ERR]  = frame_err;
        end else if (sel_div) begin
            o_prdata[DIV_W-1:0] = o_div;
        end
    end

endmodule

// File: uart/uart_tx.sv
module uart_tx
    import uart_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_tick,
    input  logic       i_empty,
    input  uart_byte_t i_data,
    output logic       o_pop,
    output logic       o_tx
);

    localparam int FRAME_BITS = DATA_BITS + 2;
    localparam int TICK_W     = $clog2(OVERSAMPLE);
    localparam int BIT_W      = $clog2(FRAME_BITS + 1);

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } state_t;

    state_t                state;
    logic [FRAME_BITS-1:0] shift_reg;
    logic [TICK_W-1:0]     tick_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic                  tx;
    logic                  bit_start;
    logic                  frame_end;

    assign bit_start = state == TX_SEND && i_tick && tick_cnt == '0;
    assign frame_end = state == TX_SEND && i_tick
                       && tick_cnt == TICK_W'(OVERSAMPLE - 1)
                       && bit_cnt == BIT_W'(FRAME_BITS);

    // Pop when idle, or at the last tick of a stop bit for back-to-back frames
    assign o_pop = !i_empty && (state == TX_IDLE || frame_end);

    // Stop, data LSB first, start
    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            shift_reg <= {1'b1, i_data, 1'b0};
        end else if (bit_start) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    if (o_pop) begin
                        state <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (bit_start) begin
                        tx      <= shift_reg[0];
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    if (frame_end) begin
                        bit_cnt <= '0;
                        if (!o_pop) begin
                            state <= TX_IDLE;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    assign o_tx = tx;

endmodule

// File: uart/uart_rx.sv
module uart_rx
    import uart_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_tick,
    input  logic     i_rx,
    output logic     o_push,
    output rx_word_t o_data
);

    localparam int TICK_W = $clog2(OVERSAMPLE);
    localparam int BIT_W  = $clog2(DATA_BITS + 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } state_t;

    state_t            state;
    logic              rx_meta;
    logic              rx_sync;
    logic              rx_prev;
    logic [TICK_W-1:0] tick_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    uart_byte_t        shift_reg;
    logic              sample;

    // Two-flop synchronizer plus one more stage for edge detection
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Half a bit after the start edge, then a full bit between samples
    assign sample = i_tick
                    && tick_cnt == (state == RX_START ? TICK_W'(OVERSAMPLE / 2 - 1)
                                                      : TICK_W'(OVERSAMPLE - 1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_push   <= 1'b0;
        end else begin
            o_push <= 1'b0;
            if (i_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (sample) begin
                        tick_cnt <= '0;
                        // Glitch, not a start bit
                        state <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (sample) begin
                        o_push <= 1'b1;
                        state  <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && sample) begin
            shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
        end
        if (state == RX_STOP && sample) begin
            o_data.data      <= shift_reg;
            o_data.frame_err <= !rx_sync;
        end
    end

endmodule

// File: uart/uart_top.sv
module uart_top
    import uart_pkg::*;
#(
    parameter int CLK_FREQ   = 1600000,
    parameter int BAUD_RATE  = 100000,
    parameter int FIFO_DEPTH = 4
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [3:0]  i_paddr,
    input  logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_tx,
    input  logic        i_rx
);

    logic [DIV_W-1:0] div;
    logic             tick;
    logic             tx_push;
    uart_byte_t       tx_wdata;
    logic             tx_pop;
    uart_byte_t       tx_rdata;
    logic             tx_full;
    logic             tx_empty;
    logic             rx_push;
    rx_word_t         rx_wdata;
    logic             rx_pop;
    rx_word_t         rx_rdata;
    logic             rx_full;
    logic             rx_empty;

    uart_regs #(
        .CLK_FREQ (CLK_FREQ),
        .BAUD_RATE(BAUD_RATE)
    ) regs_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_div     (div),
        .o_tx_push (tx_push),
        .o_tx_data (tx_wdata),
        .i_tx_full (tx_full),
        .i_tx_empty(tx_empty),
        .o_rx_pop  (rx_pop),
        .i_rx_data (rx_rdata),
        .i_rx_empty(rx_empty),
        .i_rx_push (rx_push),
        .i_rx_full (rx_full)
    );

    baud_tick tick_i (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_div (div),
        .o_tick(tick)
    );

    sync_fifo #(
        .payload_t(uart_byte_t),
        .DEPTH    (FIFO_DEPTH)
    ) tx_fifo (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_push (tx_push),
        .i_data (tx_wdata),
        .i_pop  (tx_pop),
        .o_data (tx_rdata),
        .o_full (tx_full),
        .o_empty(tx_empty)
    );

    uart_tx tx_i (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_tick (tick),
        .i_empty(tx_empty),
        .i_data (tx_rdata),
        .o_pop  (tx_pop),
        .o_tx   (o_tx)
    );

    uart_rx rx_i (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_tick(tick),
        .i_rx  (i_rx),
        .o_push(rx_push),
        .o_data(rx_wdata)
    );

    sync_fifo #(
        .payload_t(rx_word_t),
        .DEPTH    (FIFO_DEPTH)
    ) rx_fifo (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_push (rx_push),
        .i_data (rx_wdata),
        .i_pop  (rx_pop),
        .o_data (rx_rdata),
        .o_full (rx_full),
        .o_empty(rx_empty)
    );

endmodule

// File: verification/tb_clock.sv
module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// File: verification/uart_chk.sv
module uart_chk
    import uart_pkg::*;
(
    input logic             i_clk,
    input logic             i_rst,
    input logic             i_psel,
    input logic             i_penable,
    input logic             i_pwrite,
    input logic [3:0]       i_paddr,
    input logic [31:0]      i_pwdata,
    input logic [DIV_W-1:0] i_div,
    input logic             i_tx_busy,
    input logic             i_tx,
    input logic             i_tx_push,
    input logic             i_tx_full,
    input logic             i_tx_pop,
    input logic             i_tx_empty,
    input logic             i_rx_push,
    input logic             i_rx_full,
    input logic             i_rx_pop,
    input logic             i_rx_empty
);

    int fail_count = 0;

    // Line idles high between frames
    idle_high: assert property (@(posedge i_clk) disable iff (i_rst) !i_tx_busy |-> i_tx)
        else begin
            $error("o_tx is low while the transmitter is idle");
            fail_count++;
        end

    // Full stays full without a pop, empty stays empty without a push
    fifo_guard: assert property (@(posedge i_clk) disable iff (i_rst)
        (!$past(i_tx_full && !i_tx_pop) || i_tx_full)
        && (!$past(i_tx_empty && !i_tx_push) || i_tx_empty)
        && (!$past(i_rx_full && !i_rx_pop) || i_rx_full)
        && (!$past(i_rx_empty && !i_rx_push) || i_rx_empty))
        else begin
            $error("FIFO pushed while full or popped while empty");
            fail_count++;
        end

    div_write: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_psel && i_penable && i_pwrite && i_paddr == ADDR_DIV[3:0])
        |=> i_div == $past(i_pwdata[DIV_W-1:0]))
        else begin
            $error("divisor does not hold the value written to DIV");
            fail_count++;
        end

endmodule

// TX_SEND is the only nonzero transmitter state
bind uart_top uart_chk chk_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .i_div     (div),
    .i_tx_busy (tx_i.state),
    .i_tx      (o_tx),
    .i_tx_push (tx_push),
    .i_tx_full (tx_full),
    .i_tx_pop  (tx_pop),
    .i_tx_empty(tx_empty),
    .i_rx_push (rx_push),
    .i_rx_full (rx_full),
    .i_rx_pop  (rx_pop),
    .i_rx_empty(rx_empty)
);

// File: verification/uart_tb.sv
module uart_tb
    import uart_pkg::*;
;

    localparam int CLK_FREQ   = 1600000;
    localparam int BAUD_RATE  = 100000;
    localparam int FIFO_DEPTH = 4;
    localparam int FRAME_BITS = DATA_BITS + 2;
    localparam int DIV_RESET  = CLK_FREQ / (BAUD_RATE * OVERSAMPLE) - 1;
    localparam int SLOW_DIV   = 3;
    // Bytes per test at the reset divisor, then the bytes of the last test
    localparam int FAST_BYTES = 4 + 8 + (FIFO_DEPTH + 1) + 1;
    localparam int SLOW_BYTES = 2;
    localparam int WATCHDOG_CYCLES = 2 * FRAME_BITS * OVERSAMPLE
                                   * (FAST_BYTES * (DIV_RESET + 1) + SLOW_BYTES * (SLOW_DIV + 1));
    localparam logic [31:0] STATUS_IDLE = (32'd1 << STAT_TX_EMPTY) | (32'd1 << STAT_RX_EMPTY);

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        tx;
    logic        rx;
    logic        rx_loop;
    logic        rx_level;

    rx_word_t    exp_q[$];
    rx_word_t    got_q[$];
    logic [31:0] rng = 32'h3cb7;
    int          cur_div = DIV_RESET;
    int          frames_sent = 0;
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    tb_clock #(
        .PERIOD      (20),
        .RESET_CYCLES(8)
    ) clock_i (
        .o_clk(clk),
        .o_rst(rst)
    );

    // Loopback from o_tx, or a level forced by the test
    assign rx = rx_loop ? tx : rx_level;

    uart_top #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uart_top_i (
        .i_clk    (clk),
        .i_rst    (rst),
        .i_psel   (psel),
        .i_penable(penable),
        .i_pwrite (pwrite),
        .i_paddr  (paddr),
        .i_pwdata (pwdata),
        .o_prdata (prdata),
        .o_tx     (tx),
        .i_rx     (rx)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // A clean frame returns the byte, a break returns zero with the stop bit missing
    function automatic rx_word_t ref_word(input uart_byte_t sent, input logic line_break);
        rx_word_t word;
        if (line_break) begin
            word.data      = '0;
            word.frame_err = 1'b1;
        end else begin
            word.data      = sent;
            word.frame_err = 1'b0;
        end
        return word;
    endfunction

    function automatic int frame_cycles(input int div);
        return FRAME_BITS * OVERSAMPLE * (div + 1);
    endfunction

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr[3:0];
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr[3:0];
        @(posedge clk);
        penable <= 1'b1;
        // Mid access phase, well clear of the edges
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: expected 0x%0h, got 0x%0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic poll_status(input int bit_pos, input logic value, input int max_cycles,
                               input string what);
        logic [31:0] status;
        int          waited;
        waited = 0;
        apb_read(ADDR_STATUS, status);
        while (status[bit_pos] !== value && waited < max_cycles) begin
            apb_read(ADDR_STATUS, status);
            waited += 3;
        end
        assert (status[bit_pos] === value) else begin
            $display("Timed out after %0d cycles waiting for %s", waited, what);
            errors++;
        end
    endtask

    task automatic send_byte(input uart_byte_t data, input logic expect_rx);
        if (expect_rx) begin
            exp_q.push_back(ref_word(data, 1'b0));
        end
        apb_write(ADDR_DATA, {24'h0, data});
    endtask

    task automatic read_byte();
        logic [31:0] rdata;
        apb_read(ADDR_DATA, rdata);
        got_q.push_back(rx_word_t'(rdata[$bits(rx_word_t)-1:0]));
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        wait (got_q.size() == 0);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // Words read back against the reference, in order
    initial begin : compare
        rx_word_t got;
        rx_word_t exp;
        forever begin
            wait (got_q.size() > 0);
            got = got_q.pop_front();
            assert (exp_q.size() > 0) else begin
                $display("Read word 0x%03h back with no word expected", got);
                errors++;
            end
            if (exp_q.size() > 0) begin
                exp = exp_q.pop_front();
                assert (got === exp) else begin
                    $display("Mismatch rx_word: expected 0x%03h, got 0x%03h", exp, got);
                    errors++;
                end
            end
        end
    end

    // Counts frames by their start edge, then skips to the middle of the stop bit
    initial begin : frame_count
        forever begin
            @(negedge tx);
            frames_sent++;
            repeat ((FRAME_BITS * OVERSAMPLE - OVERSAMPLE / 2) * (cur_div + 1)) @(posedge clk);
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin : run
        logic [31:0] rdata;
        int          frames_before;

        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        rx_loop  = 1'b0;
        rx_level = 1'b1;
        wait (rst === 1'b0);
        @(posedge clk);
        rx_loop <= 1'b1;

        apb_read(ADDR_STATUS, rdata);
        check_value("STATUS", rdata, STATUS_IDLE);
        apb_read(ADDR_DIV, rdata);
        check_value("DIV", rdata, DIV_RESET);
        end_test("reset values");

        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            send_byte(rng[7:0], 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            poll_status(STAT_RX_EMPTY, 1'b0, 2 * frame_cycles(cur_div), "a loopback byte");
            read_byte();
        end
        end_test("loopback");

        @(posedge clk);
        rx_loop  <= 1'b0;
        rx_level <= 1'b0;
        frames_before = frames_sent;
        for (int i = 0; i < 8; i++) begin
            rng = xorshift(rng);
            send_byte(rng[7:0], 1'b0);
        end
        apb_read(ADDR_STATUS, rdata);
        check_value("STATUS.tx_full", rdata[STAT_TX_FULL], 1);
        poll_status(STAT_TX_EMPTY, 1'b1, 8 * frame_cycles(cur_div), "the TX FIFO to drain");
        // Last frame is still on the line
        repeat (frame_cycles(cur_div) + OVERSAMPLE * (cur_div + 1)) @(posedge clk);
        check_value("frames on o_tx", frames_sent - frames_before, FIFO_DEPTH + 1);
        // The forced low line arrives as one break word
        exp_q.push_back(ref_word(8'h00, 1'b1));
        rx_loop <= 1'b1;
        read_byte();
        apb_read(ADDR_STATUS, rdata);
        check_value("STATUS.rx_empty", rdata[STAT_RX_EMPTY], 1);
        apb_write(ADDR_STATUS, 32'd1 << STAT_FRAME_ERR);
        end_test("TX back-pressure");

        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            rng = xorshift(rng);
            send_byte(rng[7:0], i < FIFO_DEPTH);
        end
        poll_status(STAT_RX_OVERRUN, 1'b1, (FIFO_DEPTH + 2) * frame_cycles(cur_div),
                    "the overrun flag");
        apb_write(ADDR_STATUS, 32'd1 << STAT_RX_OVERRUN);
        apb_read(ADDR_STATUS, rdata);
        check_value("STATUS.rx_overrun", rdata[STAT_RX_OVERRUN], 0);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            read_byte();
        end
        apb_read(ADDR_STATUS, rdata);
        check_value("STATUS.rx_empty", rdata[STAT_RX_EMPTY], 1);
        end_test("RX overrun");

        @(posedge clk);
        rx_loop  <= 1'b0;
        rx_level <= 1'b0;
        exp_q.push_back(ref_word(8'h00, 1'b1));
        repeat (frame_cycles(cur_div)) @(posedge clk);
        rx_loop <= 1'b1;
        poll_status(STAT_RX_EMPTY, 1'b0, frame_cycles(cur_div), "the break word");
        apb_read(ADDR_STATUS, rdata);
        check_value("STATUS.frame_err", rdata[STAT_FRAME_ERR], 1);
        read_byte();
        apb_write(ADDR_STATUS, 32'd1 << STAT_FRAME_ERR);
        apb_read(ADDR_STATUS, rdata);
        check_value("STATUS", rdata, STATUS_IDLE);
        end_test("line break");

        apb_write(ADDR_DIV, SLOW_DIV);
        cur_div = SLOW_DIV;
        apb_read(ADDR_DIV, rdata);
        check_value("DIV", rdata, SLOW_DIV);
        for (int i = 0; i < 2; i++) begin
            rng = xorshift(rng);
            send_byte(rng[7:0], 1'b1);
        end
        for (int i = 0; i < 2; i++) begin
            poll_status(STAT_RX_EMPTY, 1'b0, 2 * frame_cycles(cur_div), "a slow loopback byte");
            read_byte();
        end
        end_test("divisor 3");

        assert (exp_q.size() == 0) else begin
            $display("%0d expected words were never read back", exp_q.size());
            errors++;
        end
        errors += uart_top_i.chk_i.fail_count;
        $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: vlog.f
common/uart_pkg.sv
logic/sync_fifo.sv
logic/baud_tick.sv
uart/uart_regs.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_top.sv
verification/tb_clock.sv
verification/uart_chk.sv
verification/uart_tb.sv

// File: Bender.yml
package:
  name: apb_uart

sources:
  - common/uart_pkg.sv
  - logic/sync_fifo.sv
  - logic/baud_tick.sv
  - uart/uart_regs.sv
  - uart/uart_tx.sv
  - uart/uart_rx.sv
  - uart/uart_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/uart_chk.sv
      - verification/uart_tb.sv
